// File: logic/ldu_pkg.sv
package ldu_pkg;

    // ------------------------------------------------------------
    // widths

    localparam int VPN_WIDTH = 20;
    localparam int PPN_WIDTH = 22;
    localparam int PO_WORD_WIDTH = 10;
    localparam int PA_WORD_WIDTH = PPN_WIDTH + PO_WORD_WIDTH;

    localparam int DCACHE_WAYS = 2;
    localparam int DCACHE_INDEX_WIDTH = 5;
    localparam int DCACHE_WORD_SEL_WIDTH = 3;
    localparam int DCACHE_BLOCK_OFFSET_WIDTH = DCACHE_WORD_SEL_WIDTH + 2;
    localparam int DCACHE_TAG_WIDTH = PPN_WIDTH;

    localparam int CQ_INDEX_WIDTH = 4;
    localparam int ROB_INDEX_WIDTH = 7;
    localparam int PR_INDEX_WIDTH = 7;

    typedef logic [VPN_WIDTH-1:0] vpn_t;
    typedef logic [PPN_WIDTH-1:0] ppn_t;
    typedef logic [PO_WORD_WIDTH-1:0] po_word_t;
    typedef logic [PA_WORD_WIDTH-1:0] pa_word_t;
    typedef logic [DCACHE_TAG_WIDTH-1:0] dcache_tag_t;
    typedef logic [DCACHE_INDEX_WIDTH-1:0] dcache_index_t;
    typedef logic [DCACHE_BLOCK_OFFSET_WIDTH-1:0] dcache_offset_t;
    typedef logic [CQ_INDEX_WIDTH-1:0] cq_index_t;
    typedef logic [ROB_INDEX_WIDTH-1:0] rob_index_t;
    typedef logic [PR_INDEX_WIDTH-1:0] pr_index_t;
    typedef logic [3:0] byte_mask_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] load_op_t;

    // load ops
    // bit 1 selects word, bit 0 halfword, bit 2 unsigned
    localparam load_op_t LOAD_OP_LB = 4'd0;
    localparam load_op_t LOAD_OP_LH = 4'd1;
    localparam load_op_t LOAD_OP_LW = 4'd2;
    localparam load_op_t LOAD_OP_LBU = 4'd4;
    localparam load_op_t LOAD_OP_LHU = 4'd5;

    // ------------------------------------------------------------
    // bundles

    typedef struct packed {
        vpn_t vpn;
        po_word_t po_word;
        byte_mask_t byte_mask;
        cq_index_t cq_index;
    } first_try_t;

    typedef struct packed {
        word_t data;
        cq_index_t cq_index;
    } data_try_t;

    typedef struct packed {
        logic hit;
        ppn_t ppn;
        logic is_mem;
        logic page_fault;
        logic access_fault;
    } dtlb_resp_t;

    typedef struct packed {
        logic [DCACHE_WAYS-1:0] valid_by_way;
        dcache_tag_t [DCACHE_WAYS-1:0] tag_by_way;
        word_t [DCACHE_WAYS-1:0] data_by_way;
    } dcache_resp_t;

    typedef struct packed {
        logic is_first;
        logic is_data;
        po_word_t po_word;
        byte_mask_t byte_mask;
        word_t data;
        cq_index_t cq_index;
    } resp_stage_t;

    typedef struct packed {
        load_op_t op;
        pr_index_t dest_pr;
        rob_index_t rob_index;
    } cq_info_t;

    typedef struct packed {
        word_t data;
        pr_index_t pr;
        rob_index_t rob_index;
    } wb_t;

    typedef struct packed {
        logic page_fault;
        logic access_fault;
        rob_index_t rob_index;
    } exception_t;

    typedef struct packed {
        cq_index_t cq_index;
        logic dtlb_hit;
        logic page_fault;
        logic access_fault;
        logic dcache_hit;
        logic is_mem;
        pa_word_t pa_word;
        byte_mask_t byte_mask;
        word_t data;
    } cq_ret_t;

endpackage

// File: logic/ldu_launch_req.sv
`timescale 1ns/1ps

module ldu_launch_req (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    first_try_valid,
    input  ldu_pkg::first_try_t     first_try,
    input  logic                    data_try_valid,
    input  ldu_pkg::data_try_t      data_try,
    input  logic                    dtlb_req_ready,
    input  logic                    dcache_req_ready,
    input  logic                    ret_stall,
    output logic                    first_try_ack,
    output logic                    data_try_ack,
    output logic                    dtlb_req_valid,
    output ldu_pkg::vpn_t           dtlb_req_vpn,
    output logic                    dcache_req_valid,
    output ldu_pkg::dcache_index_t  dcache_req_index,
    output ldu_pkg::dcache_offset_t dcache_req_block_offset,
    output logic                    resp_valid,
    output ldu_pkg::resp_stage_t    resp_stage,
    output logic                    resp_fresh
);
    import ldu_pkg::*;

    logic        stall_resp;
    logic        req_valid;
    resp_stage_t req_stage;

    // occupied response stage waits on the return stage
    assign stall_resp = resp_valid & ret_stall;

    // ------------------------------------------------------------
    // arbitration

    always_comb begin
        first_try_ack = 1'b0;
        data_try_ack = 1'b0;
        // first try also needs both lookups to take the request
        if (first_try_valid & ~stall_resp & dtlb_req_ready & dcache_req_ready) begin
            first_try_ack = 1'b1;
        end else if (data_try_valid & ~stall_resp) begin
            data_try_ack = 1'b1;
        end
    end

    assign req_valid = first_try_ack | data_try_ack;

    always_comb begin
        req_stage.is_first = first_try_ack;
        req_stage.is_data = data_try_ack;
        req_stage.po_word = first_try.po_word;
        req_stage.byte_mask = first_try.byte_mask;
        req_stage.data = data_try.data;
        req_stage.cq_index = first_try_ack ? first_try.cq_index : data_try.cq_index;
    end

    // tlb and cache lookups go out together
    assign dtlb_req_valid = first_try_ack;
    assign dtlb_req_vpn = first_try.vpn;
    assign dcache_req_valid = first_try_ack;
    assign dcache_req_index = first_try.po_word[DCACHE_WORD_SEL_WIDTH +: DCACHE_INDEX_WIDTH];
    assign dcache_req_block_offset = {first_try.po_word[DCACHE_WORD_SEL_WIDTH-1:0], 2'b00};

    // ------------------------------------------------------------
    // request to response stage

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            resp_valid <= 1'b0;
            resp_fresh <= 1'b0;
        end else begin
            // fresh only in the cycle after the stage took something
            resp_fresh <= ~stall_resp;
            if (~stall_resp) begin
                resp_valid <= req_valid;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (~stall_resp) begin
            resp_stage <= req_stage;
        end
    end

endmodule

// File: logic/ldu_translate_check.sv
`timescale 1ns/1ps

module ldu_translate_check (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 resp_fresh,
    input  ldu_pkg::resp_stage_t resp_stage,
    input  ldu_pkg::dtlb_resp_t  dtlb_resp,
    output ldu_pkg::pa_word_t    pa_word,
    output logic                 dtlb_hit,
    output logic                 page_fault,
    output logic                 access_fault,
    output logic                 is_mem
);
    import ldu_pkg::*;

    dtlb_resp_t saved_resp;
    dtlb_resp_t sel_resp;

    // tlb answer is only good in the fresh cycle
    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            saved_resp <= '0;
        end else if (resp_fresh) begin
            saved_resp <= dtlb_resp;
        end
    end

    assign sel_resp = resp_fresh ? dtlb_resp : saved_resp;

    assign pa_word = {sel_resp.ppn, resp_stage.po_word};

    // data try never looked up a translation
    assign dtlb_hit = resp_stage.is_first & sel_resp.hit;
    assign page_fault = resp_stage.is_first & sel_resp.page_fault;
    assign access_fault = resp_stage.is_first & sel_resp.access_fault;
    assign is_mem = resp_stage.is_first & sel_resp.is_mem;

endmodule

// File: logic/ldu_tag_match.sv
`timescale 1ns/1ps

module ldu_tag_match (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  resp_valid,
    input  logic                  resp_fresh,
    input  ldu_pkg::resp_stage_t  resp_stage,
    input  ldu_pkg::pa_word_t     pa_word,
    input  logic                  dtlb_hit,
    input  ldu_pkg::dcache_resp_t dcache_resp,
    output logic                  dcache_hit,
    output ldu_pkg::word_t        sel_data,
    output logic                  dcache_hit_valid,
    output logic                  dcache_hit_way,
    output logic                  dcache_miss_valid,
    output ldu_pkg::dcache_tag_t  dcache_miss_tag
);
    import ldu_pkg::*;

    dcache_resp_t           saved_resp;
    dcache_resp_t           sel_resp;
    dcache_tag_t            addr_tag;
    logic [DCACHE_WAYS-1:0] vtm_by_way;
    logic                   any_vtm;
    logic                   give_feedback;

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            saved_resp <= '0;
        end else if (resp_fresh) begin
            saved_resp <= dcache_resp;
        end
    end

    assign sel_resp = resp_fresh ? dcache_resp : saved_resp;

    // ------------------------------------------------------------
    // tag compare

    assign addr_tag = pa_word[PA_WORD_WIDTH-1 -: DCACHE_TAG_WIDTH];

    always_comb begin
        for (int w = 0; w < DCACHE_WAYS; w++) begin
            vtm_by_way[w] = sel_resp.valid_by_way[w] & (sel_resp.tag_by_way[w] == addr_tag);
        end
    end

    assign any_vtm = |vtm_by_way;
    // way 1 wins on a double match
    assign dcache_hit_way = vtm_by_way[1];
    assign dcache_hit = dtlb_hit & any_vtm;

    // feedback once per item, only with a real address
    assign give_feedback = resp_valid & resp_fresh & dtlb_hit;
    assign dcache_hit_valid = give_feedback & any_vtm;
    assign dcache_miss_valid = give_feedback & ~any_vtm;
    assign dcache_miss_tag = addr_tag;

    // ------------------------------------------------------------
    // data select

    assign sel_data = resp_stage.is_data ? resp_stage.data
                                         : sel_resp.data_by_way[dcache_hit_way];

endmodule

// File: logic/ldu_launch_ret.sv
`timescale 1ns/1ps

module ldu_launch_ret (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 resp_valid,
    input  ldu_pkg::resp_stage_t resp_stage,
    input  ldu_pkg::cq_info_t    cq_info,
    input  ldu_pkg::pa_word_t    pa_word,
    input  logic                 dtlb_hit,
    input  logic                 page_fault,
    input  logic                 access_fault,
    input  logic                 is_mem,
    input  logic                 dcache_hit,
    input  ldu_pkg::word_t       sel_data,
    input  logic                 wb_ready,
    input  logic                 exception_ready,
    output ldu_pkg::cq_index_t   cq_grab_index,
    output logic                 ret_stall,
    output logic                 wb_valid,
    output ldu_pkg::wb_t         wb,
    output logic                 exception_valid,
    output ldu_pkg::exception_t  exception,
    output logic                 cq_ret_valid,
    output ldu_pkg::cq_ret_t     cq_ret
);
    import ldu_pkg::*;

    logic     do_wb;
    logic     do_exc;
    cq_ret_t  next_item;

    logic     ret_valid;
    logic     ret_do_wb;
    logic     ret_do_exc;
    logic     ret_do_cq_ret;
    logic     ret_is_data;
    cq_info_t ret_info;
    cq_ret_t  ret_item;

    logic     perform;
    logic     is_signed;
    word_t    load_data;

    // ------------------------------------------------------------
    // response stage actions

    assign cq_grab_index = resp_stage.cq_index;

    // faults do not block writeback
    assign do_wb = resp_stage.is_data | (dtlb_hit & dcache_hit);
    assign do_exc = dtlb_hit & (page_fault | access_fault);

    always_comb begin
        next_item.cq_index = resp_stage.cq_index;
        next_item.dtlb_hit = dtlb_hit;
        next_item.page_fault = page_fault;
        next_item.access_fault = access_fault;
        next_item.dcache_hit = dcache_hit;
        next_item.is_mem = is_mem;
        next_item.pa_word = pa_word;
        next_item.byte_mask = resp_stage.byte_mask;
        next_item.data = sel_data;
    end

    // ------------------------------------------------------------
    // return stage

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            ret_valid <= 1'b0;
            ret_do_wb <= 1'b0;
            ret_do_exc <= 1'b0;
            ret_do_cq_ret <= 1'b0;
        end else if (~ret_stall) begin
            ret_valid <= resp_valid;
            ret_do_wb <= resp_valid & do_wb;
            ret_do_exc <= resp_valid & do_exc;
            ret_do_cq_ret <= resp_valid & resp_stage.is_first;
        end
    end

    always_ff @(posedge CLK) begin
        if (~ret_stall) begin
            ret_is_data <= resp_stage.is_data;
            ret_info <= cq_info;
            ret_item <= next_item;
        end
    end

    // cq return always accepted
    assign ret_stall = ret_valid & ((ret_do_wb & ~wb_ready) | (ret_do_exc & ~exception_ready));
    assign perform = ret_valid & ~ret_stall;

    // ------------------------------------------------------------
    // load data extraction

    assign is_signed = ~ret_info.op[2];

    always_comb begin
        if (ret_is_data | ret_info.op[1]) begin
            load_data = ret_item.data;
        end else if (ret_info.op[0]) begin
            // halfword picked by the cleared mask bit
            if (~ret_item.byte_mask[1]) begin
                load_data = {{16{is_signed & ret_item.data[31]}}, ret_item.data[31:16]};
            end else if (~ret_item.byte_mask[0]) begin
                load_data = {{16{is_signed & ret_item.data[23]}}, ret_item.data[23:8]};
            end else begin
                load_data = {{16{is_signed & ret_item.data[15]}}, ret_item.data[15:0]};
            end
        end else begin
            // byte lane of highest mask bit
            if (ret_item.byte_mask[3]) begin
                load_data = {{24{is_signed & ret_item.data[31]}}, ret_item.data[31:24]};
            end else if (ret_item.byte_mask[2]) begin
                load_data = {{24{is_signed & ret_item.data[23]}}, ret_item.data[23:16]};
            end else if (ret_item.byte_mask[1]) begin
                load_data = {{24{is_signed & ret_item.data[15]}}, ret_item.data[15:8]};
            end else begin
                load_data = {{24{is_signed & ret_item.data[7]}}, ret_item.data[7:0]};
            end
        end
    end

    // ------------------------------------------------------------
    // outputs

    assign wb_valid = ret_do_wb & perform;
    assign wb.data = load_data;
    assign wb.pr = ret_info.dest_pr;
    assign wb.rob_index = ret_info.rob_index;

    assign exception_valid = ret_do_exc & perform;
    assign exception.page_fault = ret_item.page_fault;
    assign exception.access_fault = ret_item.access_fault;
    assign exception.rob_index = ret_info.rob_index;

    assign cq_ret_valid = ret_do_cq_ret & perform;
    assign cq_ret = ret_item;

endmodule

// File: logic/ldu_launch_pipeline.sv
`timescale 1ns/1ps

module ldu_launch_pipeline (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    first_try_valid,
    input  ldu_pkg::first_try_t     first_try,
    output logic                    first_try_ack,
    input  logic                    data_try_valid,
    input  ldu_pkg::data_try_t      data_try,
    output logic                    data_try_ack,
    output logic                    dtlb_req_valid,
    output ldu_pkg::vpn_t           dtlb_req_vpn,
    input  logic                    dtlb_req_ready,
    input  ldu_pkg::dtlb_resp_t     dtlb_resp,
    output logic                    dcache_req_valid,
    output ldu_pkg::dcache_index_t  dcache_req_index,
    output ldu_pkg::dcache_offset_t dcache_req_block_offset,
    input  logic                    dcache_req_ready,
    input  ldu_pkg::dcache_resp_t   dcache_resp,
    output logic                    dcache_hit_valid,
    output logic                    dcache_hit_way,
    output logic                    dcache_miss_valid,
    output ldu_pkg::dcache_tag_t    dcache_miss_tag,
    output ldu_pkg::cq_index_t      cq_grab_index,
    input  ldu_pkg::cq_info_t       cq_info,
    output logic                    wb_valid,
    output ldu_pkg::wb_t            wb,
    input  logic                    wb_ready,
    output logic                    exception_valid,
    output ldu_pkg::exception_t     exception,
    input  logic                    exception_ready,
    output logic                    cq_ret_valid,
    output ldu_pkg::cq_ret_t        cq_ret
);
    import ldu_pkg::*;

    logic        resp_valid;
    resp_stage_t resp_stage;
    logic        resp_fresh;
    pa_word_t    pa_word;
    logic        dtlb_hit;
    logic        page_fault;
    logic        access_fault;
    logic        is_mem;
    logic        dcache_hit;
    word_t       sel_data;
    logic        ret_stall;

    ldu_launch_req i_ldu_launch_req (
        .CLK(CLK),
        .nRST(nRST),
        .first_try_valid(first_try_valid),
        .first_try(first_try),
        .data_try_valid(data_try_valid),
        .data_try(data_try),
        .dtlb_req_ready(dtlb_req_ready),
        .dcache_req_ready(dcache_req_ready),
        .ret_stall(ret_stall),
        .first_try_ack(first_try_ack),
        .data_try_ack(data_try_ack),
        .dtlb_req_valid(dtlb_req_valid),
        .dtlb_req_vpn(dtlb_req_vpn),
        .dcache_req_valid(dcache_req_valid),
        .dcache_req_index(dcache_req_index),
        .dcache_req_block_offset(dcache_req_block_offset),
        .resp_valid(resp_valid),
        .resp_stage(resp_stage),
        .resp_fresh(resp_fresh)
    );

    // response stage, tlb side
    ldu_translate_check i_ldu_translate_check (
        .CLK(CLK),
        .nRST(nRST),
        .resp_fresh(resp_fresh),
        .resp_stage(resp_stage),
        .dtlb_resp(dtlb_resp),
        .pa_word(pa_word),
        .dtlb_hit(dtlb_hit),
        .page_fault(page_fault),
        .access_fault(access_fault),
        .is_mem(is_mem)
    );

    // response stage, cache side
    ldu_tag_match i_ldu_tag_match (
        .CLK(CLK),
        .nRST(nRST),
        .resp_valid(resp_valid),
        .resp_fresh(resp_fresh),
        .resp_stage(resp_stage),
        .pa_word(pa_word),
        .dtlb_hit(dtlb_hit),
        .dcache_resp(dcache_resp),
        .dcache_hit(dcache_hit),
        .sel_data(sel_data),
        .dcache_hit_valid(dcache_hit_valid),
        .dcache_hit_way(dcache_hit_way),
        .dcache_miss_valid(dcache_miss_valid),
        .dcache_miss_tag(dcache_miss_tag)
    );

    ldu_launch_ret i_ldu_launch_ret (
        .CLK(CLK),
        .nRST(nRST),
        .resp_valid(resp_valid),
        .resp_stage(resp_stage),
        .cq_info(cq_info),
        .pa_word(pa_word),
        .dtlb_hit(dtlb_hit),
        .page_fault(page_fault),
        .access_fault(access_fault),
        .is_mem(is_mem),
        .dcache_hit(dcache_hit),
        .sel_data(sel_data),
        .wb_ready(wb_ready),
        .exception_ready(exception_ready),
        .cq_grab_index(cq_grab_index),
        .ret_stall(ret_stall),
        .wb_valid(wb_valid),
        .wb(wb),
        .exception_valid(exception_valid),
        .exception(exception),
        .cq_ret_valid(cq_ret_valid),
        .cq_ret(cq_ret)
    );

endmodule

// File: verification/ldu_launch_properties.sv
`timescale 1ns/1ps

module ldu_launch_properties (
    input logic                 CLK,
    input logic                 nRST,
    input logic                 ret_stall,
    input logic                 resp_valid,
    input logic                 resp_fresh,
    input ldu_pkg::resp_stage_t resp_stage,
    input logic                 first_try_ack,
    input logic                 data_try_ack,
    input logic                 dtlb_req_valid,
    input logic                 dcache_req_valid,
    input logic                 dcache_hit_valid,
    input logic                 dcache_miss_valid,
    input logic                 wb_valid,
    input ldu_pkg::wb_t         wb,
    input logic                 exception_valid,
    input ldu_pkg::exception_t  exception,
    input logic                 cq_ret_valid,
    input ldu_pkg::cq_ret_t     cq_ret
);

    // ------------------------------------------------------------
    // back-pressure holds the return and response stages

    a_ret_stable: assert property (@(posedge CLK) disable iff (!nRST)
        ret_stall |=> $stable(wb) && $stable(exception) && $stable(cq_ret))
        else $error("return stage payload moved while stalled");

    a_resp_stable: assert property (@(posedge CLK) disable iff (!nRST)
        resp_valid && ret_stall |=> resp_valid && $stable(resp_stage))
        else $error("response stage moved while blocked");

    // hit or miss feedback only right after a first try was taken
    a_feedback_once: assert property (@(posedge CLK) disable iff (!nRST)
        (dcache_hit_valid || dcache_miss_valid) |->
            $past(first_try_ack) && !(dcache_hit_valid && dcache_miss_valid))
        else $error("cache feedback without a first try taken the cycle before");

    a_reset_quiet: assert property (@(posedge CLK)
        !nRST |-> !(wb_valid || exception_valid || cq_ret_valid || first_try_ack
                    || data_try_ack || dtlb_req_valid || dcache_req_valid))
        else $error("valid output during reset");

endmodule

bind ldu_launch_pipeline ldu_launch_properties i_ldu_launch_properties (
    .CLK(CLK),
    .nRST(nRST),
    .ret_stall(ret_stall),
    .resp_valid(resp_valid),
    .resp_fresh(resp_fresh),
    .resp_stage(resp_stage),
    .first_try_ack(first_try_ack),
    .data_try_ack(data_try_ack),
    .dtlb_req_valid(dtlb_req_valid),
    .dcache_req_valid(dcache_req_valid),
    .dcache_hit_valid(dcache_hit_valid),
    .dcache_miss_valid(dcache_miss_valid),
    .wb_valid(wb_valid),
    .wb(wb),
    .exception_valid(exception_valid),
    .exception(exception),
    .cq_ret_valid(cq_ret_valid),
    .cq_ret(cq_ret)
);

// File: verification/ldu_launch_tb.sv
`timescale 1ns/1ps

module ldu_launch_tb;
    import ldu_pkg::*;

    typedef struct packed {
        logic        has_wb;
        wb_t         wb;
        logic        has_exc;
        exception_t  exc;
        logic        has_cq;
        cq_ret_t     cq;
        logic [31:0] ack_cycle;
    } expect_t;

    logic CLK, nRST;
    logic first_try_valid, first_try_ack, data_try_valid, data_try_ack;
    first_try_t first_try;
    data_try_t data_try;
    logic dtlb_req_valid, dtlb_req_ready, dcache_req_valid, dcache_req_ready;
    vpn_t dtlb_req_vpn;
    dcache_index_t dcache_req_index;
    dcache_offset_t dcache_req_block_offset;
    dtlb_resp_t dtlb_resp;
    dcache_resp_t dcache_resp;
    logic dcache_hit_valid, dcache_hit_way, dcache_miss_valid;
    dcache_tag_t dcache_miss_tag;
    cq_index_t cq_grab_index;
    cq_info_t cq_info;
    logic wb_valid, wb_ready, exception_valid, exception_ready, cq_ret_valid;
    wb_t wb;
    exception_t exception;
    cq_ret_t cq_ret;

    cq_info_t cq_table [16];
    expect_t exp_q [$];
    dtlb_resp_t pend_tlb;
    dcache_resp_t pend_dc;
    logic resp_due, fb_hit, fb_miss, fb_way, stim_on, back_pressure;
    logic first_taken, data_taken;
    dcache_tag_t fb_tag;
    logic [31:0] cycle;
    logic [5:0] reached;

    ldu_launch_pipeline i_ldu_launch_pipeline (.*);

    // central-queue table answers in the same cycle
    always_comb cq_info = cq_table[cq_grab_index];

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_failure(input string what);
        $display("%0t: %s", $time, what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // loaded value per the load-op and byte mask rules
    function automatic word_t extract(input load_op_t op, input byte_mask_t mask,
                                      input word_t w);
        logic sgn;
        logic [15:0] h;
        logic [7:0] b;
        sgn = ~op[2];
        if (op[1]) return w;
        if (op[0]) begin
            h = !mask[1] ? w[31:16] : (!mask[0] ? w[23:8] : w[15:0]);
            return {{16{sgn & h[15]}}, h};
        end
        b = mask[3] ? w[31:24] : (mask[2] ? w[23:16] : (mask[1] ? w[15:8] : w[7:0]));
        return {{24{sgn & b[7]}}, b};
    endfunction

    // ------------------------------------------------------------
    // per-cycle drive and sample

    task automatic drive_inputs();
        logic [127:0] junk;
        logic [31:0] r;
        junk = {$urandom(), $urandom(), $urandom(), $urandom()};
        // answers follow the request by one cycle, then junk
        dtlb_resp = resp_due ? pend_tlb : junk[25:0];
        dcache_resp = resp_due ? pend_dc : junk[109:0];
        r = $urandom();
        if (!first_try_valid || first_taken) begin
            first_try_valid = stim_on && (r[1:0] != 0);
            first_try.vpn = junk[19:0];
            first_try.po_word = junk[29:20];
            first_try.byte_mask = junk[33:30];
            first_try.cq_index = junk[37:34];
        end
        if (!data_try_valid || data_taken) begin
            data_try_valid = stim_on && (r[3:2] == 0);
            data_try.data = junk[69:38];
            data_try.cq_index = junk[73:70];
        end
        dtlb_req_ready = r[6:4] != 0;
        dcache_req_ready = r[9:7] != 0;
        wb_ready = !back_pressure || r[10];
        exception_ready = !back_pressure || r[11];
    endtask

    task automatic check_feedback();
        check_value("dcache_hit_valid", 128'(dcache_hit_valid), 128'(fb_hit));
        check_value("dcache_miss_valid", 128'(dcache_miss_valid), 128'(fb_miss));
        if (fb_hit) check_value("dcache_hit_way", 128'(dcache_hit_way), 128'(fb_way));
        if (fb_miss) check_value("dcache_miss_tag", 128'(dcache_miss_tag), 128'(fb_tag));
    endtask

    task automatic check_outputs();
        expect_t e;
        if (wb_valid || exception_valid || cq_ret_valid) begin
            if (exp_q.size() == 0) report_failure("output with no item in flight");
            e = exp_q.pop_front();
            check_value("wb_valid", 128'(wb_valid), 128'(e.has_wb));
            check_value("exception_valid", 128'(exception_valid), 128'(e.has_exc));
            check_value("cq_ret_valid", 128'(cq_ret_valid), 128'(e.has_cq));
            if (e.has_wb) check_value("wb", 128'(wb), 128'(e.wb));
            if (e.has_exc) check_value("exception", 128'(exception), 128'(e.exc));
            if (e.has_cq) check_value("cq_ret", 128'(cq_ret), 128'(e.cq));
            if (!back_pressure) check_value("latency", 128'(cycle), 128'(e.ack_cycle + 2));
            // behaviors seen so far
            if (e.has_wb && e.has_cq) reached[0] = 1'b1;
            if (e.has_cq && e.cq.dtlb_hit && !e.cq.dcache_hit) reached[1] = 1'b1;
            if (e.has_cq && !e.cq.dtlb_hit) reached[2] = 1'b1;
            if (e.has_exc) reached[3] = 1'b1;
            if (e.has_wb && !e.has_cq) reached[4] = 1'b1;
            if (cycle != e.ack_cycle + 2) reached[5] = 1'b1;
        end
    endtask

    task automatic record_acks();
        expect_t e;
        logic [1:0] vtm;
        logic [31:0] r;
        cq_info_t info;
        if (first_try_ack && data_try_ack) report_failure("both acks high in one cycle");
        if (data_try_ack && first_try_valid && dtlb_req_ready && dcache_req_ready)
            report_failure("data try taken over a ready first try");
        if (first_try_ack && !(first_try_valid && dtlb_req_ready && dcache_req_ready))
            report_failure("first try taken without valid and both readies");
        if (data_try_ack && !data_try_valid)
            report_failure("data try taken without valid");
        // lookups go out only with a taken first try
        check_value("dtlb_req_valid", 128'(dtlb_req_valid), 128'(first_try_ack));
        check_value("dcache_req_valid", 128'(dcache_req_valid), 128'(first_try_ack));
        if (first_try_ack) begin
            check_value("dtlb_req_vpn", 128'(dtlb_req_vpn), 128'(first_try.vpn));
            check_value("dcache_req_index", 128'(dcache_req_index),
                        128'(first_try.po_word[7:3]));
            check_value("dcache_req_block_offset", 128'(dcache_req_block_offset),
                        128'({first_try.po_word[2:0], 2'b00}));
        end
        first_taken = first_try_ack;
        data_taken = data_try_ack;
        resp_due = first_try_ack;
        fb_hit = 1'b0;
        fb_miss = 1'b0;
        e = '0;
        e.ack_cycle = cycle;
        if (first_try_ack) begin
            r = $urandom();
            pend_tlb.hit = r[1:0] != 0;
            pend_tlb.page_fault = r[4:2] == 0;
            pend_tlb.access_fault = r[7:5] == 0;
            pend_tlb.is_mem = r[8];
            pend_tlb.ppn = r[31:10];
            for (int w = 0; w < DCACHE_WAYS; w++) begin
                r = $urandom();
                pend_dc.valid_by_way[w] = r[1:0] != 0;
                pend_dc.tag_by_way[w] = r[2] ? pend_tlb.ppn : r[31:10];
                pend_dc.data_by_way[w] = $urandom();
                vtm[w] = pend_dc.valid_by_way[w] && (pend_dc.tag_by_way[w] == pend_tlb.ppn);
            end
            info = cq_table[first_try.cq_index];
            e.has_cq = 1'b1;
            e.cq.cq_index = first_try.cq_index;
            e.cq.dtlb_hit = pend_tlb.hit;
            e.cq.page_fault = pend_tlb.page_fault;
            e.cq.access_fault = pend_tlb.access_fault;
            e.cq.dcache_hit = pend_tlb.hit && (|vtm);
            e.cq.is_mem = pend_tlb.is_mem;
            e.cq.pa_word = {pend_tlb.ppn, first_try.po_word};
            e.cq.byte_mask = first_try.byte_mask;
            e.cq.data = pend_dc.data_by_way[vtm[1]];
            e.has_wb = e.cq.dcache_hit;
            e.wb.data = extract(info.op, first_try.byte_mask, e.cq.data);
            e.wb.pr = info.dest_pr;
            e.wb.rob_index = info.rob_index;
            e.has_exc = pend_tlb.hit && (pend_tlb.page_fault || pend_tlb.access_fault);
            e.exc.page_fault = pend_tlb.page_fault;
            e.exc.access_fault = pend_tlb.access_fault;
            e.exc.rob_index = info.rob_index;
            fb_hit = e.cq.dcache_hit;
            fb_miss = pend_tlb.hit && !(|vtm);
            fb_way = vtm[1];
            fb_tag = pend_tlb.ppn;
        end else if (data_try_ack) begin
            info = cq_table[data_try.cq_index];
            e.has_wb = 1'b1;
            e.wb.data = data_try.data;
            e.wb.pr = info.dest_pr;
            e.wb.rob_index = info.rob_index;
        end
        if (first_try_ack || data_try_ack) begin
            exp_q.push_back(e);
        end
    endtask

    task automatic run_cycle();
        @(negedge CLK);
        drive_inputs();
        #10;
        check_feedback();
        check_outputs();
        record_acks();
        cycle++;
    endtask

    // ------------------------------------------------------------
    // stimulus

    initial begin
        logic [31:0] r;
        int unsigned wait_count;
        void'($urandom(32'hdac1f579));
        nRST = 1'b0;
        {first_try_valid, data_try_valid, dtlb_req_ready, dcache_req_ready} = '0;
        {wb_ready, exception_ready} = '0;
        first_try = '0;
        data_try = '0;
        dtlb_resp = '0;
        dcache_resp = '0;
        {resp_due, fb_hit, fb_miss, fb_way, back_pressure} = '0;
        {first_taken, data_taken} = '0;
        fb_tag = '0;
        pend_tlb = '0;
        pend_dc = '0;
        stim_on = 1'b1;
        cycle = '0;
        reached = '0;
        for (int i = 0; i < 16; i++) begin
            r = $urandom();
            case (r[2:0] % 5)
                0: cq_table[i].op = LOAD_OP_LB;
                1: cq_table[i].op = LOAD_OP_LH;
                2: cq_table[i].op = LOAD_OP_LW;
                3: cq_table[i].op = LOAD_OP_LBU;
                default: cq_table[i].op = LOAD_OP_LHU;
            endcase
            cq_table[i].dest_pr = r[9:3];
            cq_table[i].rob_index = r[16:10];
        end
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        for (int i = 0; i < 300; i++) run_cycle();
        back_pressure = 1'b1;
        for (int i = 0; i < 600; i++) run_cycle();

        // drain what is still in flight
        stim_on = 1'b0;
        wait_count = 0;
        while (first_try_valid || data_try_valid || exp_q.size() != 0) begin
            if (wait_count == 400) report_failure("timeout while draining the pipeline");
            run_cycle();
            wait_count++;
        end
        if (&reached) begin
            $display("All tests passed");
            $finish;
        end else begin
            report_failure("not every load behavior was reached");
        end
    end

endmodule

// File: project.f
logic/ldu_pkg.sv
logic/ldu_launch_req.sv
logic/ldu_translate_check.sv
logic/ldu_tag_match.sv
logic/ldu_launch_ret.sv
logic/ldu_launch_pipeline.sv
verification/ldu_launch_properties.sv
verification/ldu_launch_tb.sv

// File: run.sh
#!/bin/sh
# build and run the load unit launch testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module ldu_launch_tb -f project.f \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vldu_launch_tb > sim.log 2>&1
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
